// File: compile.f
+incdir+design
design/cpu_pkg.sv
design/cpu_pipe_reg.sv
design/cpu_regfile.sv
design/cpu_decode.sv
design/cpu_execute.sv
design/cpu_result.sv
design/cpu_top.sv
dv/cpu_assert.sv
dv/tb_cpu.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Regression passed
FAIL_MSG = Regression failed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu;

	localparam int N_PROGS = 20;
	localparam int N_WORDS = 64;
	localparam int RESET_CYCLES = 3;
	localparam int DRAIN_CYCLES = 12;
	// four cycles per instruction covers stalls and flushes
	localparam int CYCLE_LIMIT = N_PROGS * N_WORDS * 4 +
		N_PROGS * (RESET_CYCLES + DRAIN_CYCLES) + 100;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic [`CPU_PC_W-1:0]  instr_addr;
	logic [`CPU_XLEN-1:0]  instr;
	logic                  retire_valid;
	logic [`CPU_REG_W-1:0] retire_reg;
	logic [`CPU_XLEN-1:0]  retire_data;

	logic [`CPU_XLEN-1:0]  prog [N_WORDS];
	// expected retires as {register, value}
	logic [`CPU_REG_W+`CPU_XLEN-1:0] exp_q [$];
	logic [31:0] rng;
	string test_name = "reset";
	int cycle_count = 0;
	int prog_retires = 0;
	int retires = 0;
	int value_errors = 0;
	int other_errors = 0;

	always #10 clk = ~clk;

	// instruction memory returns zero past the program
	assign instr = (instr_addr < `CPU_PC_W'(N_WORDS)) ? prog[instr_addr[5:0]] : '0;

	cpu_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.instr_addr(instr_addr),
		.instr(instr),
		.retire_valid(retire_valid),
		.retire_reg(retire_reg),
		.retire_data(retire_data)
	);

	bind cpu_top cpu_assert i_assert (
		.clk(clk),
		.rst_n(rst_n),
		.instr_addr(instr_addr),
		.retire_valid(retire_valid),
		.retire_reg(retire_reg)
	);

	////////////////////
	// stimulus helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [4:0] alu_opcode(input int k);
		case (k)
			0: return `CPU_OP_ADD;
			1: return `CPU_OP_ADDI;
			2: return `CPU_OP_SUB;
			3: return `CPU_OP_AND;
			4: return `CPU_OP_ANDI;
			5: return `CPU_OP_OR;
			6: return `CPU_OP_ORI;
			7: return `CPU_OP_XOR;
			8: return `CPU_OP_SLL;
			9: return `CPU_OP_SRL;
			default: return `CPU_OP_SRA;
		endcase
	endfunction

	task automatic build_program();
		logic [31:0] r;
		logic [31:0] f;
		logic [4:0] op;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		for (int i = 0; i < N_WORDS; i++) begin
			rng = xorshift32(rng);
			r = rng;
			rng = xorshift32(rng);
			f = rng;
			// eight registers keep dependencies close and hit r0 often
			rd = {2'b00, f[2:0]};
			rs1 = {2'b00, f[5:3]};
			rs2 = {2'b00, f[8:6]};
			op = alu_opcode(int'(r[7:4]) % 11);
			if (r[3:0] < 4'd9) begin
				if (op == `CPU_OP_ADDI || op == `CPU_OP_ANDI || op == `CPU_OP_ORI) begin
					prog[i] = {op, rd, rs1, f[9], f[31:16]};
				end else begin
					prog[i] = {op, rd, rs1, rs2, f[27:16]};
				end
			end else if (r[3:0] < 4'd13) begin
				prog[i] = {r[8] ? `CPU_OP_LUI : `CPU_OP_LLI, rd, rs1, f[9], f[31:16]};
			end else begin
				// forward offset of 0 to 3 words
				prog[i] = {`CPU_OP_B, f[11:9], f[13:12], rs1, 1'b0, 14'd0, f[15:14]};
			end
		end
	endtask

	////////////////////
	// ISA model
	////////////////////

	function automatic logic branch_taken(input logic [2:0] c, input logic z, input logic s,
		input logic v);
		case (c)
			3'd0: return !z;
			3'd1: return z;
			3'd2: return !z && !s;
			3'd3: return !z && s;
			3'd4: return z || !s;
			3'd5: return z || s;
			3'd6: return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		longint wide;
		logic [4:0] op;
		logic [4:0] rd;
		logic zf;
		logic sf;
		logic vf;
		logic ov;
		logic full;
		logic half;
		logic jump;
		int pc;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		{zf, sf, vf} = 3'b000;
		pc = 0;
		exp_q.delete();
		while (pc < N_WORDS) begin
			w = prog[pc];
			op = w[31:27];
			rd = w[26:22];
			a = regs[w[21:17]];
			b = regs[w[16:12]];
			if (op == `CPU_OP_ADDI || op == `CPU_OP_ANDI || op == `CPU_OP_ORI) begin
				b = {{16{w[15]}}, w[15:0]};
			end
			res = '0;
			ov = 1'b0;
			full = 1'b1;
			half = 1'b0;
			jump = 1'b0;
			case (op)
				// overflow when the exact signed result does not fit in 32 bits
				`CPU_OP_ADD, `CPU_OP_ADDI: begin
					res = a + b;
					wide = longint'($signed(a)) + longint'($signed(b));
					ov = (wide != longint'($signed(res)));
				end
				`CPU_OP_SUB: begin
					res = a - b;
					wide = longint'($signed(a)) - longint'($signed(b));
					ov = (wide != longint'($signed(res)));
				end
				`CPU_OP_AND, `CPU_OP_ANDI: res = a & b;
				`CPU_OP_OR, `CPU_OP_ORI: res = a | b;
				`CPU_OP_XOR: res = a ^ b;
				`CPU_OP_SLL: res = a << b[4:0];
				`CPU_OP_SRL: res = a >> b[4:0];
				`CPU_OP_SRA: res = $signed(a) >>> b[4:0];
				`CPU_OP_LLI: begin
					res = {regs[rd][31:16], w[15:0]};
					full = 1'b0;
					half = 1'b1;
				end
				`CPU_OP_LUI: begin
					res = {w[15:0], regs[rd][15:0]};
					full = 1'b0;
					half = 1'b1;
				end
				`CPU_OP_B: begin
					jump = branch_taken(w[26:24], zf, sf, vf);
					full = 1'b0;
				end
				default: full = 1'b0;
			endcase
			// the all-zero word is a no-op and leaves the flags alone
			if (w == '0) begin
				full = 1'b0;
			end
			pc = pc + 1;
			if (jump) begin
				pc = pc + int'(w[15:0]);
			end
			if (full) begin
				{zf, sf, vf} = {res == '0, res[31], ov};
			end
			if ((full || half) && rd != '0) begin
				regs[rd] = res;
				exp_q.push_back({rd, res});
			end
		end
	endtask

	////////////////////
	// checking
	////////////////////

	always @(negedge clk) begin
		logic [`CPU_REG_W+`CPU_XLEN-1:0] head;
		if (rst_n && retire_valid) begin
			retires++;
			prog_retires++;
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("%s: unexpected retire of r%0d = %h", test_name, retire_reg,
					retire_data);
			end else begin
				head = exp_q.pop_front();
				if ({retire_reg, retire_data} != head) begin
					value_errors++;
					$display("ERROR %s: retire %0d expected r%0d=%h actual r%0d=%h",
						test_name, prog_retires, head[36:32], head[31:0], retire_reg,
						retire_data);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles in %s, %0d value errors, %0d other errors",
				cycle_count, test_name, value_errors, other_errors);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		rng = 32'hd008;
		for (int p = 0; p < N_PROGS; p++) begin
			rst_n = 1'b0;
			test_name = $sformatf("program_%0d", p);
			build_program();
			run_model();
			prog_retires = 0;
			repeat (RESET_CYCLES) @(posedge clk);
			#2 rst_n = 1'b1;
			// run until the fetch leaves the program and then let the pipe drain
			while (int'(instr_addr) < N_WORDS) begin
				@(posedge clk);
				#2;
			end
			repeat (DRAIN_CYCLES) @(posedge clk);
			#2;
			if (exp_q.size() != 0) begin
				other_errors++;
				$display("%s: %0d expected retires never appeared", test_name, exp_q.size());
			end
			if (prog_retires == 0) begin
				other_errors++;
				$display("%s: no instruction retired", test_name);
			end
		end
		$display("%0d retires checked, %0d value errors, %0d other errors", retires,
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/cpu_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_assert (
	input logic                  clk,
	input logic                  rst_n,
	input logic [`CPU_PC_W-1:0]  instr_addr,
	input logic                  retire_valid,
	input logic [`CPU_REG_W-1:0] retire_reg
);

	// cycles since reset release, saturating at four
	logic [2:0] since_rst;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			since_rst <= '0;
		end else if (since_rst != 3'd4) begin
			since_rst <= since_rst + 3'd1;
		end
	end

	// r0 writes are dropped in the register file
	retire_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> (retire_reg != '0))
		else $error("retire reported for register 0");

	// the first instruction needs all four stages first
	no_early_retire: assert property (@(posedge clk) disable iff (!rst_n)
		(since_rst < 3'd4) |-> !retire_valid)
		else $error("retire within four cycles of reset");

	pc_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(instr_addr))
		else $error("instr_addr has unknown bits");

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_top import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic [`CPU_PC_W-1:0]  instr_addr,
	input  logic [`CPU_XLEN-1:0]  instr,
	output logic                  retire_valid,
	output logic [`CPU_REG_W-1:0] retire_reg,
	output logic [`CPU_XLEN-1:0]  retire_data
);

	logic [`CPU_REG_W-1:0] raddr1;
	logic [`CPU_REG_W-1:0] raddr2;
	logic [`CPU_XLEN-1:0]  rdata1;
	logic [`CPU_XLEN-1:0]  rdata2;
	flags_t                flags;
	logic                  flags_pending;
	half_dest_t            ex_half_dest;
	half_dest_t            mem_half_dest;
	half_dest_t            wb_half_dest;
	logic                  id_valid;
	id_ex_t                id_data;
	logic                  ex_valid;
	ex_mem_t               ex_data;
	logic                  fwd_mem_valid;
	logic [`CPU_REG_W-1:0] fwd_mem_dest;
	logic [`CPU_XLEN-1:0]  fwd_mem_value;
	logic                  fwd_wb_valid;
	logic [`CPU_REG_W-1:0] fwd_wb_dest;
	logic [`CPU_XLEN-1:0]  fwd_wb_value;
	logic                  wen;
	logic                  wlower;
	logic                  wupper;
	logic [`CPU_REG_W-1:0] waddr;
	logic [`CPU_XLEN-1:0]  wdata;

	cpu_decode i_decode (
		.clk(clk), .rst_n(rst_n),
		.instr(instr), .instr_addr(instr_addr),
		.raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
		.flags(flags), .flags_pending(flags_pending),
		.ex_half_dest(ex_half_dest), .mem_half_dest(mem_half_dest),
		.wb_half_dest(wb_half_dest),
		.id_valid(id_valid), .id_data(id_data)
	);

	cpu_execute i_execute (
		.clk(clk), .rst_n(rst_n),
		.id_valid(id_valid), .id_data(id_data),
		.fwd_mem_valid(fwd_mem_valid), .fwd_mem_dest(fwd_mem_dest),
		.fwd_mem_value(fwd_mem_value),
		.fwd_wb_valid(fwd_wb_valid), .fwd_wb_dest(fwd_wb_dest), .fwd_wb_value(fwd_wb_value),
		.flags(flags), .flags_pending(flags_pending), .ex_half_dest(ex_half_dest),
		.ex_valid(ex_valid), .ex_data(ex_data)
	);

	cpu_result i_result (
		.clk(clk), .rst_n(rst_n),
		.ex_valid(ex_valid), .ex_data(ex_data),
		.fwd_mem_valid(fwd_mem_valid), .fwd_mem_dest(fwd_mem_dest),
		.fwd_mem_value(fwd_mem_value),
		.fwd_wb_valid(fwd_wb_valid), .fwd_wb_dest(fwd_wb_dest), .fwd_wb_value(fwd_wb_value),
		.mem_half_dest(mem_half_dest), .wb_half_dest(wb_half_dest),
		.wen(wen), .wlower(wlower), .wupper(wupper), .waddr(waddr), .wdata(wdata)
	);

	cpu_regfile i_regfile (
		.clk(clk), .rst_n(rst_n),
		.raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
		.wen(wen), .wlower(wlower), .wupper(wupper), .waddr(waddr), .wdata(wdata),
		.retire_valid(retire_valid), .retire_reg(retire_reg), .retire_data(retire_data)
	);

endmodule

`default_nettype wire

// File: design/cpu_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_result import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ex_valid,
	input  ex_mem_t               ex_data,
	output logic                  fwd_mem_valid,
	output logic [`CPU_REG_W-1:0] fwd_mem_dest,
	output logic [`CPU_XLEN-1:0]  fwd_mem_value,
	output logic                  fwd_wb_valid,
	output logic [`CPU_REG_W-1:0] fwd_wb_dest,
	output logic [`CPU_XLEN-1:0]  fwd_wb_value,
	output half_dest_t            mem_half_dest,
	output half_dest_t            wb_half_dest,
	output logic                  wen,
	output logic                  wlower,
	output logic                  wupper,
	output logic [`CPU_REG_W-1:0] waddr,
	output logic [`CPU_XLEN-1:0]  wdata
);

	logic    em_valid;
	ex_mem_t em;
	mem_wb_t mw_in;
	logic    mw_valid;
	mem_wb_t mw;

	cpu_pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
		.clk(clk),
		.rst_n(rst_n),
		.hold(1'b0),
		.valid_in(ex_valid),
		.data_in(ex_data),
		.valid(em_valid),
		.data(em)
	);

	// memory slot passes the result through
	assign mw_in.result = em.result;
	assign mw_in.wb = em.wb;

	cpu_pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
		.clk(clk),
		.rst_n(rst_n),
		.hold(1'b0),
		.valid_in(em_valid),
		.data_in(mw_in),
		.valid(mw_valid),
		.data(mw)
	);

	// only full writes forward, r0 excluded
	assign fwd_mem_valid = em_valid && em.wb.wr_full && (em.wb.dest != '0);
	assign fwd_mem_dest = em.wb.dest;
	assign fwd_mem_value = em.result;
	assign fwd_wb_valid = mw_valid && mw.wb.wr_full && (mw.wb.dest != '0);
	assign fwd_wb_dest = mw.wb.dest;
	assign fwd_wb_value = mw.result;

	assign mem_half_dest.valid = em_valid && (em.wb.wr_lower || em.wb.wr_upper);
	assign mem_half_dest.dest = em.wb.dest;
	assign wb_half_dest.valid = mw_valid && (mw.wb.wr_lower || mw.wb.wr_upper);
	assign wb_half_dest.dest = mw.wb.dest;

	assign wen = mw_valid && mw.wb.wr_full;
	assign wlower = mw_valid && mw.wb.wr_lower;
	assign wupper = mw_valid && mw.wb.wr_upper;
	assign waddr = mw.wb.dest;
	assign wdata = mw.result;

endmodule

`default_nettype wire

// File: design/cpu_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_execute import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  id_valid,
	input  id_ex_t                id_data,
	input  logic                  fwd_mem_valid,
	input  logic [`CPU_REG_W-1:0] fwd_mem_dest,
	input  logic [`CPU_XLEN-1:0]  fwd_mem_value,
	input  logic                  fwd_wb_valid,
	input  logic [`CPU_REG_W-1:0] fwd_wb_dest,
	input  logic [`CPU_XLEN-1:0]  fwd_wb_value,
	output flags_t                flags,
	output logic                  flags_pending,
	output half_dest_t            ex_half_dest,
	output logic                  ex_valid,
	output ex_mem_t               ex_data
);

	localparam int MSB = `CPU_XLEN - 1;

	logic                 ie_valid;
	id_ex_t               ie;
	logic [`CPU_XLEN-1:0] a;
	logic [`CPU_XLEN-1:0] b;
	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] diff;
	logic [`CPU_XLEN-1:0] alu_res;
	logic                 ovf;

	cpu_pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
		.clk(clk),
		.rst_n(rst_n),
		.hold(1'b0),
		.valid_in(id_valid),
		.data_in(id_data),
		.valid(ie_valid),
		.data(ie)
	);

	// forwarding, nearest producer first
	always_comb begin
		if (fwd_mem_valid && fwd_mem_dest == ie.ex.src1) begin
			a = fwd_mem_value;
		end else if (fwd_wb_valid && fwd_wb_dest == ie.ex.src1) begin
			a = fwd_wb_value;
		end else begin
			a = ie.op1;
		end
		if (ie.ex.use_imm) begin
			b = ie.imm;
		end else if (fwd_mem_valid && fwd_mem_dest == ie.ex.src2) begin
			b = fwd_mem_value;
		end else if (fwd_wb_valid && fwd_wb_dest == ie.ex.src2) begin
			b = fwd_wb_value;
		end else begin
			b = ie.op2;
		end
	end

	////////////////////
	// alu
	////////////////////

	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		ovf = 1'b0;
		case (ie.ex.alu_op)
			ALU_ADD: begin
				alu_res = sum;
				ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			ALU_SUB: begin
				alu_res = diff;
				ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			ALU_AND: alu_res = a & b;
			ALU_OR:  alu_res = a | b;
			ALU_XOR: alu_res = a ^ b;
			ALU_SLL: alu_res = a << b[4:0];
			ALU_SRL: alu_res = a >> b[4:0];
			ALU_SRA: alu_res = $signed(a) >>> b[4:0];
			default: alu_res = sum;
		endcase
	end

	// flag register, written at the end of EX
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (ie_valid && ie.ex.upd_flags) begin
			flags.zero <= (alu_res == '0);
			flags.sign <= alu_res[MSB];
			flags.overflow <= ovf;
		end
	end

	assign flags_pending = ie_valid && ie.ex.upd_flags;
	assign ex_half_dest.valid = ie_valid && (ie.wb.wr_lower || ie.wb.wr_upper);
	assign ex_half_dest.dest = ie.wb.dest;

	assign ex_valid = ie_valid;
	assign ex_data.result = ie.ex.sel_imm ? ie.imm : alu_res;
	assign ex_data.wb = ie.wb;

endmodule

`default_nettype wire

// File: design/cpu_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_decode import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`CPU_XLEN-1:0]  instr,
	output logic [`CPU_PC_W-1:0]  instr_addr,
	output logic [`CPU_REG_W-1:0] raddr1,
	output logic [`CPU_REG_W-1:0] raddr2,
	input  logic [`CPU_XLEN-1:0]  rdata1,
	input  logic [`CPU_XLEN-1:0]  rdata2,
	input  flags_t                flags,
	input  logic                  flags_pending,
	input  half_dest_t            ex_half_dest,
	input  half_dest_t            mem_half_dest,
	input  half_dest_t            wb_half_dest,
	output logic                  id_valid,
	output id_ex_t                id_data
);

	logic [`CPU_PC_W-1:0] pc;
	logic                 ifid_valid;
	logic [`CPU_XLEN-1:0] ifid_instr;
	logic [`CPU_PC_W-1:0] ifid_pc;
	logic [`CPU_XLEN-1:0] imm;
	logic                 is_branch;
	logic                 cond;
	logic                 stall;
	logic                 taken;

	function automatic logic half_hit(input half_dest_t hd, input logic [`CPU_REG_W-1:0] a1,
		input logic [`CPU_REG_W-1:0] a2);
		return hd.valid && (hd.dest == a1 || hd.dest == a2);
	endfunction

	////////////////////
	// fetch
	////////////////////

	assign instr_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (taken) begin
			pc <= ifid_pc + `CPU_PC_W'(1) + imm[`CPU_PC_W-1:0];
		end else if (!stall) begin
			pc <= pc + `CPU_PC_W'(1);
		end
	end

	// a taken branch flushes the slot behind it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ifid_valid <= 1'b0;
		end else if (taken) begin
			ifid_valid <= 1'b0;
		end else if (!stall) begin
			ifid_valid <= (instr != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && !taken) begin
			ifid_instr <= instr;
			ifid_pc <= pc;
		end
	end

	////////////////////
	// decode
	////////////////////

	assign raddr1 = ifid_instr[21:17];
	assign raddr2 = ifid_instr[16:12];
	assign imm = {{(`CPU_XLEN-`CPU_IMM_W){ifid_instr[`CPU_IMM_W-1]}}, ifid_instr[`CPU_IMM_W-1:0]};

	always_comb begin
		id_data = '0;
		is_branch = 1'b0;
		id_data.op1 = rdata1;
		id_data.op2 = rdata2;
		id_data.imm = imm;
		id_data.ex.src1 = raddr1;
		id_data.ex.src2 = raddr2;
		id_data.wb.dest = ifid_instr[26:22];
		case (ifid_instr[31:27])
			`CPU_OP_ADD:  id_data.ex.alu_op = ALU_ADD;
			`CPU_OP_ADDI: id_data.ex.alu_op = ALU_ADD;
			`CPU_OP_SUB:  id_data.ex.alu_op = ALU_SUB;
			`CPU_OP_AND:  id_data.ex.alu_op = ALU_AND;
			`CPU_OP_ANDI: id_data.ex.alu_op = ALU_AND;
			`CPU_OP_OR:   id_data.ex.alu_op = ALU_OR;
			`CPU_OP_ORI:  id_data.ex.alu_op = ALU_OR;
			`CPU_OP_XOR:  id_data.ex.alu_op = ALU_XOR;
			`CPU_OP_SLL:  id_data.ex.alu_op = ALU_SLL;
			`CPU_OP_SRL:  id_data.ex.alu_op = ALU_SRL;
			`CPU_OP_SRA:  id_data.ex.alu_op = ALU_SRA;
			default:      id_data.ex.alu_op = ALU_ADD;
		endcase
		case (ifid_instr[31:27])
			`CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR,
			`CPU_OP_SLL, `CPU_OP_SRL, `CPU_OP_SRA: begin
				id_data.ex.upd_flags = 1'b1;
				id_data.wb.wr_full = 1'b1;
			end
			`CPU_OP_ADDI, `CPU_OP_ANDI, `CPU_OP_ORI: begin
				id_data.ex.use_imm = 1'b1;
				id_data.ex.upd_flags = 1'b1;
				id_data.wb.wr_full = 1'b1;
			end
			`CPU_OP_LLI: begin
				id_data.ex.sel_imm = 1'b1;
				id_data.wb.wr_lower = 1'b1;
			end
			`CPU_OP_LUI: begin
				id_data.ex.sel_imm = 1'b1;
				id_data.wb.wr_upper = 1'b1;
			end
			`CPU_OP_B: is_branch = 1'b1;
			// dropped opcodes fall through as no-ops
			default: ;
		endcase
	end

	// branch conditions on the flags
	always_comb begin
		case (ifid_instr[26:24])
			3'b000:  cond = !flags.zero;
			3'b001:  cond = flags.zero;
			3'b010:  cond = !flags.zero && !flags.sign;
			3'b011:  cond = !flags.zero && flags.sign;
			3'b100:  cond = flags.zero || !flags.sign;
			3'b101:  cond = flags.zero || flags.sign;
			3'b110:  cond = flags.overflow;
			default: cond = 1'b1;
		endcase
	end

	////////////////////
	// hazards
	////////////////////

	assign stall = ifid_valid && ((is_branch && flags_pending) ||
		half_hit(ex_half_dest, raddr1, raddr2) ||
		half_hit(mem_half_dest, raddr1, raddr2) ||
		half_hit(wb_half_dest, raddr1, raddr2));

	assign taken = ifid_valid && is_branch && cond && !stall;
	assign id_valid = ifid_valid && !stall;

endmodule

`default_nettype wire

// File: design/cpu_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_regfile import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`CPU_REG_W-1:0] raddr1,
	input  logic [`CPU_REG_W-1:0] raddr2,
	output logic [`CPU_XLEN-1:0]  rdata1,
	output logic [`CPU_XLEN-1:0]  rdata2,
	input  logic                  wen,
	input  logic                  wlower,
	input  logic                  wupper,
	input  logic [`CPU_REG_W-1:0] waddr,
	input  logic [`CPU_XLEN-1:0]  wdata,
	output logic                  retire_valid,
	output logic [`CPU_REG_W-1:0] retire_reg,
	output logic [`CPU_XLEN-1:0]  retire_data
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREG];
	logic [`CPU_XLEN-1:0] cur;
	logic [`CPU_XLEN-1:0] merged;
	logic                 we;

	// r0 is never written
	assign we = (wen || wlower || wupper) && (waddr != '0);
	assign cur = regs[waddr];

	// half writes take the low half of wdata
	always_comb begin
		if (wlower) begin
			merged = {cur[`CPU_XLEN-1:`CPU_IMM_W], wdata[`CPU_IMM_W-1:0]};
		end else if (wupper) begin
			merged = {wdata[`CPU_IMM_W-1:0], cur[`CPU_IMM_W-1:0]};
		end else begin
			merged = wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= merged;
		end
	end

	// write-through so a read in the writeback cycle sees the new value
	assign rdata1 = (raddr1 == '0) ? '0 : (we && waddr == raddr1) ? merged : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : (we && waddr == raddr2) ? merged : regs[raddr2];

	assign retire_valid = we;
	assign retire_reg = waddr;
	assign retire_data = merged;

endmodule

`default_nettype wire

// File: design/cpu_pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,
	input  logic     valid_in,
	input  payload_t data_in,
	output logic     valid,
	output payload_t data
);

	// bubbles carry an all-zero payload so no control bit leaks through
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
			data <= '0;
		end else if (!hold) begin
			valid <= valid_in;
			if (valid_in) begin
				data <= data_in;
			end else begin
				data <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_t;

	typedef struct packed {
		logic zero;
		logic sign;
		logic overflow;
	} flags_t;

	// execute stage controls
	typedef struct packed {
		alu_op_t alu_op;
		logic use_imm;
		logic sel_imm;
		logic upd_flags;
		logic [`CPU_REG_W-1:0] src1;
		logic [`CPU_REG_W-1:0] src2;
	} ex_ctrl_t;

	// writeback controls
	typedef struct packed {
		logic [`CPU_REG_W-1:0] dest;
		logic wr_full;
		logic wr_lower;
		logic wr_upper;
	} wb_ctrl_t;

	// pending lower/upper write seen by decode
	typedef struct packed {
		logic valid;
		logic [`CPU_REG_W-1:0] dest;
	} half_dest_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] op1;
		logic [`CPU_XLEN-1:0] op2;
		logic [`CPU_XLEN-1:0] imm;
		ex_ctrl_t ex;
		wb_ctrl_t wb;
	} id_ex_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] result;
		wb_ctrl_t wb;
	} ex_mem_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] result;
		wb_ctrl_t wb;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and field widths
`define CPU_XLEN  32
`define CPU_PC_W  16
`define CPU_REG_W 5
`define CPU_IMM_W 16
`define CPU_NREG  32

// opcode field [31:27]
`define CPU_OP_ADD  5'b00000
`define CPU_OP_ADDI 5'b00001
`define CPU_OP_SUB  5'b00010
`define CPU_OP_AND  5'b00011
`define CPU_OP_ANDI 5'b00100
`define CPU_OP_OR   5'b00101
`define CPU_OP_ORI  5'b00110
`define CPU_OP_XOR  5'b00111
`define CPU_OP_SLL  5'b01000
`define CPU_OP_SRL  5'b01001
`define CPU_OP_SRA  5'b01010
`define CPU_OP_LLI  5'b01011
`define CPU_OP_LUI  5'b01100
`define CPU_OP_B    5'b10001

`endif
